// ==== addrTranslate.sv ====
`timescale 1ns/1ps
`include "memStage_consts.svh"

module addrTranslate (
    input  logic [31:0] vaddr,
    output logic [31:0] paddr
);

    logic unmapped;

    // kseg0 and kseg1 both map onto the low 512 MB
    assign unmapped = (vaddr >= `KSEG_LOW) && (vaddr <= `KSEG_HIGH);

    always_comb begin
        if (unmapped) begin
            paddr = vaddr & `PHYS_MASK;
        end else begin
            // no TLB, kuseg and kseg2/3 go straight through
            paddr = vaddr;
        end
    end

endmodule

// ==== build.f ====
+incdir+.
memStagePkg.sv
dbusIf.sv
addrTranslate.sv
storeAlign.sv
memStage.sv
dbusArbiter.sv
memSubsystem.sv
tbWbMemory.sv
memSubsystemTb.sv

// ==== dbusArbiter.sv ====
`timescale 1ns/1ps
`include "memStage_consts.svh"

module dbusArbiter (
    input  logic                 clk,
    input  logic                 arstN,
    dbusIf.arbiter               lane0If,
    dbusIf.arbiter               lane1If,
    output logic                 stall,
    output logic                 wbCyc,
    output logic                 wbStb,
    output logic                 wbWe,
    output logic [`WB_ADR_W-1:0] wbAdr,
    output logic [3:0]           wbSel,
    output logic [31:0]          wbDatW,
    input  logic [31:0]          wbDatR,
    input  logic                 wbAck
);
    import memStagePkg::*;

    arbState     state;
    logic        pend0;
    logic        pend1;
    logic        anyReq;
    logic        ackSeen;
    logic        loadBus;
    laneReq      selReq;
    logic [31:0] data0;
    logic [31:0] data1;

    assign anyReq  = lane0If.req.valid || lane1If.req.valid;
    assign ackSeen = wbStb && wbAck;

    // out of idle lane 1 goes first, later transfers are always lane 0
    assign selReq = (state == idle && lane1If.req.valid) ? lane1If.req : lane0If.req;

    // start a transfer leaving idle, or after the idle bus cycle following lane 1
    assign loadBus = (state == idle && anyReq) || (state == busLane0 && !wbCyc);

    always_comb begin
        case (state)
            idle:     stall = anyReq;
            busLane1: stall = 1'b1;
            busLane0: stall = 1'b1;
            default:  stall = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= idle;
            pend0 <= 1'b0;
            pend1 <= 1'b0;
            wbCyc <= 1'b0;
            wbStb <= 1'b0;
            wbWe  <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (anyReq) begin
                        pend0 <= lane0If.req.valid;
                        pend1 <= lane1If.req.valid;
                        state <= lane1If.req.valid ? busLane1 : busLane0;
                    end
                end
                busLane1: begin
                    if (ackSeen) begin
                        state <= pend0 ? busLane0 : finish;
                    end
                end
                busLane0: begin
                    if (ackSeen) begin
                        state <= finish;
                    end
                end
                default: begin
                    // finish lasts one cycle
                    state <= idle;
                end
            endcase

            if (loadBus) begin
                wbCyc <= 1'b1;
                wbStb <= 1'b1;
                wbWe  <= selReq.write;
            end else if (ackSeen) begin
                wbCyc <= 1'b0;
                wbStb <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (loadBus) begin
            wbAdr  <= selReq.addr[31 -: `WB_ADR_W];
            wbSel  <= selReq.strobe;
            wbDatW <= selReq.data;
        end
        // read word captured at each lane's ack
        if (ackSeen && state == busLane1) begin
            data1 <= wbDatR;
        end
        if (ackSeen && state == busLane0) begin
            data0 <= wbDatR;
        end
    end

    assign lane0If.done  = (state == finish) && pend0;
    assign lane1If.done  = (state == finish) && pend1;
    assign lane0If.rdata = data0;
    assign lane1If.rdata = data1;

    assert property (@(posedge clk) disable iff (!arstN) wbStb |-> wbCyc)
        else $error("wbStb high without wbCyc");

    // classic cycle holds until ack
    assert property (@(posedge clk) disable iff (!arstN)
        (wbStb && !wbAck) |=> wbStb && $stable({wbWe, wbAdr, wbSel, wbDatW}))
        else $error("bus changed before ack: adr %h sel %h", wbAdr, wbSel);

    assert property (@(posedge clk) disable iff (!arstN)
        (state == idle && !anyReq) |-> !stall)
        else $error("stall in idle with no request");

endmodule

// ==== dbusIf.sv ====
`timescale 1ns/1ps

interface dbusIf;
    import memStagePkg::*;

    // request from the stage
    laneReq      req;
    // completion back from the arbiter
    logic        done;
    logic [31:0] rdata;

    modport stage (
        output req,
        input  done,
        input  rdata
    );

    modport arbiter (
        input  req,
        output done,
        output rdata
    );

endinterface

// ==== memStage.sv ====
`timescale 1ns/1ps

module memStage (
    input  logic                clk,
    input  logic                arstN,
    input  logic [31:0]         aluOut [2],
    input  logic [31:0]         srcB [2],
    input  memStagePkg::accSize size [2],
    input  logic                memRead [2],
    input  logic                memWrite [2],
    input  logic                excIn [2],
    output memStagePkg::excCode excOut [2],
    output logic                squash0,
    dbusIf.stage                lane0If,
    dbusIf.stage                lane1If
);
    import memStagePkg::*;

    logic [31:0] paddr [2];
    logic [31:0] wdata [2];
    logic [3:0]  strobe [2];
    logic        alignErr [2];
    logic        loadMis [2];
    excCode      excDet [2];
    laneReq      req [2];

    for (genvar i = 0; i < 2; i++) begin : gLane
        addrTranslate u_addrTranslate (
            .vaddr (aluOut[i]),
            .paddr (paddr[i])
        );

        storeAlign u_storeAlign (
            .addrLow  (aluOut[i][1:0]),
            .srcData  (srcB[i]),
            .size     (size[i]),
            .wdata    (wdata[i]),
            .strobe   (strobe[i]),
            .misalign (alignErr[i])
        );

        // each lane checks its own address
        assign loadMis[i] = (size[i] == size2 && aluOut[i][0])
                         || (size[i] == size4 && aluOut[i][1:0] != 2'b00);

        always_comb begin
            excDet[i] = excNone;
            // an exception from an earlier stage wins
            if (!excIn[i]) begin
                if (memWrite[i] && alignErr[i]) begin
                    excDet[i] = excAdes;
                end else if (memRead[i] && !memWrite[i] && loadMis[i]) begin
                    excDet[i] = excAdel;
                end
            end
        end

        // lane 1 is older so only lane 0 can be squashed
        assign excOut[i] = (i == 0 && squash0) ? excNone : excDet[i];

        always_comb begin
            req[i] = '0;
            if (memRead[i] || memWrite[i]) begin
                req[i].valid = !excIn[i] && (excDet[i] == excNone) && !(i == 0 && squash0);
                req[i].write = memWrite[i];
                req[i].addr  = paddr[i];
                req[i].size  = size[i];
                // loads return the whole word
                req[i].strobe = memWrite[i] ? strobe[i] : 4'b1111;
                req[i].data   = memWrite[i] ? wdata[i] : 32'h0;
            end
        end

        // a lane with an exception never reaches the bus
        assert property (@(posedge clk) disable iff (!arstN)
            req[i].valid |-> (excOut[i] == excNone))
            else $error("lane %0d: request valid with exception %0d", i, excOut[i]);
    end

    // any lane 1 exception squashes the younger lane 0
    assign squash0 = excIn[1] || (excDet[1] != excNone);

    assign lane0If.req = req[0];
    assign lane1If.req = req[1];

endmodule

// ==== memStagePkg.sv ====
package memStagePkg;

    // access width in bytes
    typedef enum logic [1:0] {
        size1 = 2'd0,
        size2 = 2'd1,
        size4 = 2'd2
    } accSize;

    // address errors raised by this stage
    typedef enum logic [1:0] {
        excNone = 2'd0,
        excAdel = 2'd1,
        excAdes = 2'd2
    } excCode;

    // bus arbiter FSM
    typedef enum logic [1:0] {
        idle     = 2'd0,
        busLane1 = 2'd1,
        busLane0 = 2'd2,
        finish   = 2'd3
    } arbState;

    // one lane's data-bus request
    typedef struct packed {
        logic        valid;
        logic        write;
        logic [31:0] addr;
        accSize      size;
        logic [3:0]  strobe;
        logic [31:0] data;
    } laneReq;

endpackage

// ==== memStage_consts.svh ====
`ifndef MEMSTAGE_CONSTS_SVH
`define MEMSTAGE_CONSTS_SVH

// kseg0 starts here, kseg1 ends here
`define KSEG_LOW 32'h8000_0000
`define KSEG_HIGH 32'hBFFF_FFFF

// drops the segment bits of kseg0/kseg1 addresses
`define PHYS_MASK 32'h1FFF_FFFF

// word address on the data bus
`define WB_ADR_W 30

// depth of the memory model
`define TB_MEM_WORDS 256

`endif

// ==== memSubsystem.sv ====
`timescale 1ns/1ps
`include "memStage_consts.svh"

module memSubsystem (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic [31:0]          aluOut [2],
    input  logic [31:0]          srcB [2],
    input  memStagePkg::accSize  size [2],
    input  logic                 memRead [2],
    input  logic                 memWrite [2],
    input  logic                 excIn [2],
    output memStagePkg::excCode  excOut [2],
    output logic                 squash0,
    output logic                 stall,
    output logic                 done0,
    output logic                 done1,
    output logic [31:0]          rdata0,
    output logic [31:0]          rdata1,
    output logic                 wbCyc,
    output logic                 wbStb,
    output logic                 wbWe,
    output logic [`WB_ADR_W-1:0] wbAdr,
    output logic [3:0]           wbSel,
    output logic [31:0]          wbDatW,
    input  logic [31:0]          wbDatR,
    input  logic                 wbAck
);

    // one link per lane between stage and arbiter
    dbusIf lane0If ();
    dbusIf lane1If ();

    memStage u_memStage (
        .clk      (clk),
        .arstN    (arstN),
        .aluOut   (aluOut),
        .srcB     (srcB),
        .size     (size),
        .memRead  (memRead),
        .memWrite (memWrite),
        .excIn    (excIn),
        .excOut   (excOut),
        .squash0  (squash0),
        .lane0If  (lane0If.stage),
        .lane1If  (lane1If.stage)
    );

    dbusArbiter u_dbusArbiter (
        .clk     (clk),
        .arstN   (arstN),
        .lane0If (lane0If.arbiter),
        .lane1If (lane1If.arbiter),
        .stall   (stall),
        .wbCyc   (wbCyc),
        .wbStb   (wbStb),
        .wbWe    (wbWe),
        .wbAdr   (wbAdr),
        .wbSel   (wbSel),
        .wbDatW  (wbDatW),
        .wbDatR  (wbDatR),
        .wbAck   (wbAck)
    );

    // completions out to the writeback side
    assign done0  = lane0If.done;
    assign done1  = lane1If.done;
    assign rdata0 = lane0If.rdata;
    assign rdata1 = lane1If.rdata;

endmodule

// ==== memSubsystemTb.sv ====
`timescale 1ns/1ps
`include "memStage_consts.svh"

module memSubsystemTb;
    import memStagePkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_TESTS = 20;
    // two accesses per test, eight cycles for each
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_TESTS * 2 * 8;

    logic                 clk = 1'b0;
    logic                 arstN;
    logic [31:0]          aluOut [2];
    logic [31:0]          srcB [2];
    accSize               size [2];
    logic                 memRead [2];
    logic                 memWrite [2];
    logic                 excIn [2];
    excCode               excOut [2];
    logic                 squash0;
    logic                 stall;
    logic                 done0;
    logic                 done1;
    logic [31:0]          rdata0;
    logic [31:0]          rdata1;
    logic                 wbCyc;
    logic                 wbStb;
    logic                 wbWe;
    logic [`WB_ADR_W-1:0] wbAdr;
    logic [3:0]           wbSel;
    logic [31:0]          wbDatW;
    logic [31:0]          wbDatR;
    logic                 wbAck;

    // next lane inputs, indexed by lane
    logic                 stRd [2];
    logic                 stWr [2];
    logic                 stExc [2];
    logic [31:0]          stAddr [2];
    logic [31:0]          stData [2];
    accSize               stSize [2];
    // expected transfers in bus order
    logic [`WB_ADR_W-1:0] expAdr [2];
    logic [3:0]           expSel [2];
    logic [31:0]          expDat [2];
    logic                 expWe [2];
    // expected per-lane results
    logic                 expDone [2];
    logic                 expLoad [2];
    logic [31:0]          expRd [2];
    excCode               expExc [2];
    logic                 expSquash;
    int                   expCount;
    int                   xferIdx;
    int                   errCount;
    int                   cycleCount;
    logic [31:0]          shadow [`TB_MEM_WORDS];

    memSubsystem u_memSubsystem (.*);
    tbWbMemory u_tbWbMemory (.*);

    always #2 clk = ~clk;

    task automatic failRun(input string msg);
        $display("%s", msg);
        errCount++;
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // kseg0 and kseg1 lose their three segment bits
    function automatic logic [31:0] physAddr(input logic [31:0] va);
        return (va[31:30] == 2'b10) ? {3'b000, va[28:0]} : va;
    endfunction

    function automatic logic misaligned(input accSize sz, input logic [1:0] off);
        return (sz == size2 && off[0]) || (sz == size4 && off != 2'b00);
    endfunction

    function automatic logic [3:0] byteSel(input accSize sz, input logic [1:0] off);
        case (sz)
            size1:   return 4'b0001 << off;
            size2:   return 4'b0011 << off;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] laneData(input accSize sz, input logic [31:0] d);
        case (sz)
            size1:   return {4{d[7:0]}};
            size2:   return {2{d[15:0]}};
            default: return d;
        endcase
    endfunction

    function automatic logic [31:0] mergeBytes(input logic [31:0] old, input logic [31:0] d,
                                               input logic [3:0] sel);
        logic [31:0] w;
        int          b;
        w = old;
        for (b = 0; b < 4; b++) begin
            if (sel[b]) begin
                w[8*b +: 8] = d[8*b +: 8];
            end
        end
        return w;
    endfunction

    // every bit of the word index shows up in the word
    function automatic logic [31:0] fillWord(input int idx);
        return {idx[7:0], ~idx[7:0], idx[7:0] ^ 8'h5A, 8'hC3};
    endfunction

    task automatic setLane(input int i, input logic rd, input logic wr, input logic exc,
                           input logic [31:0] addr, input logic [31:0] data, input accSize sz);
        stRd[i]   = rd;
        stWr[i]   = wr;
        stExc[i]  = exc;
        stAddr[i] = addr;
        stData[i] = data;
        stSize[i] = sz;
    endtask

    task automatic applyAndWait();
        int          i;
        int          k;
        int          n;
        int          idx;
        logic [31:0] pa;
        logic [1:0]  off;
        logic        killed;
        @(posedge clk);
        #1;
        n = 0;
        expSquash = 1'b0;
        // lane 1 first, it is older and goes first on the bus
        for (k = 0; k < 2; k++) begin
            i = 1 - k;
            off = stAddr[i][1:0];
            killed = (i == 0) && expSquash;
            expExc[i] = excNone;
            expDone[i] = 1'b0;
            expLoad[i] = 1'b0;
            if (!killed && !stExc[i] && misaligned(stSize[i], off)) begin
                expExc[i] = stWr[i] ? excAdes : (stRd[i] ? excAdel : excNone);
            end else if (!killed && !stExc[i] && (stRd[i] || stWr[i])) begin
                pa = physAddr(stAddr[i]);
                idx = (pa >> 2) % `TB_MEM_WORDS;
                expAdr[n] = pa[31:2];
                expWe[n] = stWr[i];
                expDone[i] = 1'b1;
                if (stWr[i]) begin
                    expSel[n] = byteSel(stSize[i], off);
                    expDat[n] = laneData(stSize[i], stData[i]);
                    shadow[idx] = mergeBytes(shadow[idx], expDat[n], expSel[n]);
                end else begin
                    expSel[n] = 4'hF;
                    expLoad[i] = 1'b1;
                    expRd[i] = shadow[idx];
                end
                n++;
            end
            if (i == 1) begin
                expSquash = stExc[1] || (expExc[1] != excNone);
            end
        end
        for (k = 0; k < 2; k++) begin
            aluOut[k] = stAddr[k];
            srcB[k] = stData[k];
            size[k] = stSize[k];
            memRead[k] = stRd[k];
            memWrite[k] = stWr[k];
            excIn[k] = stExc[k];
        end
        expCount = n;
        xferIdx = 0;
        // finish cycle, or at once when nothing reaches the bus
        do begin
            @(negedge clk);
        end while (stall);
    endtask

    always @(posedge clk) begin
        if (wbStb && wbAck) begin
            xferIdx <= xferIdx + 1;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            failRun($sformatf("timeout after %0d cycles without finishing", TIMEOUT_CYCLES));
        end
    end

    assert property (@(posedge clk) $rose(arstN) |-> !wbCyc && !wbStb && !stall && !done0 && !done1)
        else failRun("bus, stall or done not low after reset");
    assert property (@(posedge clk) disable iff (!arstN) wbCyc |-> xferIdx < expCount)
        else failRun("Wishbone cycle for an access that must not reach the bus");
    assert property (@(posedge clk) disable iff (!arstN) wbStb |-> wbAdr == expAdr[xferIdx])
        else failRun($sformatf("FAILED wbAdr: got %h expected %h",
            $sampled(wbAdr), expAdr[$sampled(xferIdx)]));
    assert property (@(posedge clk) disable iff (!arstN) wbStb |-> wbWe == expWe[xferIdx])
        else failRun($sformatf("FAILED wbWe: got %h expected %h",
            $sampled(wbWe), expWe[$sampled(xferIdx)]));
    assert property (@(posedge clk) disable iff (!arstN) wbStb |-> wbSel == expSel[xferIdx])
        else failRun($sformatf("FAILED wbSel: got %h expected %h",
            $sampled(wbSel), expSel[$sampled(xferIdx)]));
    assert property (@(posedge clk) disable iff (!arstN)
        wbStb && wbWe |-> wbDatW == expDat[xferIdx])
        else failRun($sformatf("FAILED wbDatW: got %h expected %h",
            $sampled(wbDatW), expDat[$sampled(xferIdx)]));
    assert property (@(posedge clk) disable iff (!arstN) expCount == 0 |-> !stall)
        else failRun("stall raised although no access goes to the bus");
    assert property (@(posedge clk) disable iff (!arstN) $fell(stall) |-> xferIdx == expCount)
        else failRun($sformatf("stall dropped after %0d of %0d transfers",
            $sampled(xferIdx), expCount));
    // both completions in the one finish cycle
    assert property (@(posedge clk) disable iff (!arstN)
        (done0 || done1 || $fell(stall)) |-> done0 == expDone[0] && done1 == expDone[1])
        else failRun($sformatf("FAILED done1 done0: got %h %h expected %h %h",
            $sampled(done1), $sampled(done0), expDone[1], expDone[0]));
    assert property (@(posedge clk) disable iff (!arstN) done0 && expLoad[0] |-> rdata0 == expRd[0])
        else failRun($sformatf("FAILED rdata0: got %h expected %h", $sampled(rdata0), expRd[0]));
    assert property (@(posedge clk) disable iff (!arstN) done1 && expLoad[1] |-> rdata1 == expRd[1])
        else failRun($sformatf("FAILED rdata1: got %h expected %h", $sampled(rdata1), expRd[1]));
    assert property (@(posedge clk) disable iff (!arstN) excOut[0] == expExc[0])
        else failRun($sformatf("FAILED excOut[0]: got %h expected %h",
            $sampled(excOut[0]), expExc[0]));
    assert property (@(posedge clk) disable iff (!arstN) excOut[1] == expExc[1])
        else failRun($sformatf("FAILED excOut[1]: got %h expected %h",
            $sampled(excOut[1]), expExc[1]));
    assert property (@(posedge clk) disable iff (!arstN) squash0 == expSquash)
        else failRun($sformatf("FAILED squash0: got %h expected %h", $sampled(squash0), expSquash));

    initial begin
        int k;
        arstN = 1'b0;
        errCount = 0;
        cycleCount = 0;
        expCount = 0;
        xferIdx = 0;
        expSquash = 1'b0;
        for (k = 0; k < 2; k++) begin
            setLane(k, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0, size4);
            aluOut[k] = 32'h0;
            srcB[k] = 32'h0;
            size[k] = size4;
            memRead[k] = 1'b0;
            memWrite[k] = 1'b0;
            excIn[k] = 1'b0;
            expExc[k] = excNone;
            expDone[k] = 1'b0;
            expLoad[k] = 1'b0;
        end
        for (k = 0; k < `TB_MEM_WORDS; k++) begin
            shadow[k] = fillWord(k);
            u_tbWbMemory.mem[k] = fillWord(k);
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arstN = 1'b1;

        // translation and store alignment, read back through kseg1
        setLane(1, 0, 1, 0, 32'h8000_0100, 32'h1122_3344, size4);
        setLane(0, 0, 0, 0, 32'h0, 32'h0, size4);
        applyAndWait();
        setLane(1, 0, 0, 0, 32'h0, 32'h0, size4);
        setLane(0, 1, 0, 0, 32'hA000_0100, 32'h0, size4);
        applyAndWait();
        setLane(1, 0, 1, 0, 32'h8000_0105, 32'h0000_00AB, size1);
        setLane(0, 0, 1, 0, 32'h8000_010A, 32'h0000_BEEF, size2);
        applyAndWait();
        setLane(1, 1, 0, 0, 32'h8000_0104, 32'h0, size4);
        setLane(0, 1, 0, 0, 32'h8000_0108, 32'h0, size4);
        applyAndWait();
        // kuseg and kseg2 pass through
        setLane(1, 1, 0, 0, 32'h0000_0110, 32'h0, size4);
        setLane(0, 0, 1, 0, 32'h0000_0113, 32'h0000_007E, size1);
        applyAndWait();
        setLane(1, 1, 0, 0, 32'hC000_0120, 32'h0, size4);
        setLane(0, 0, 1, 0, 32'hC000_0124, 32'hCAFE_F00D, size4);
        applyAndWait();
        // misaligned accesses
        setLane(1, 0, 0, 0, 32'h0, 32'h0, size4);
        setLane(0, 1, 0, 0, 32'h8000_0102, 32'h0, size4);
        applyAndWait();
        setLane(0, 0, 1, 0, 32'h8000_0101, 32'h0000_1234, size2);
        applyAndWait();
        // lane 1 exceptions squash lane 0
        setLane(1, 1, 0, 0, 32'h8000_0131, 32'h0, size2);
        setLane(0, 0, 1, 0, 32'h8000_0134, 32'h0F0F_0F0F, size4);
        applyAndWait();
        setLane(1, 1, 0, 1, 32'h8000_0138, 32'h0, size4);
        setLane(0, 0, 1, 0, 32'h8000_013C, 32'h7777_7777, size4);
        applyAndWait();
        // lane 0 exceptions leave lane 1 alone
        setLane(1, 0, 1, 0, 32'h8000_0140, 32'h0BAD_CAFE, size4);
        setLane(0, 0, 1, 0, 32'h8000_0142, 32'h1111_2222, size4);
        applyAndWait();
        setLane(1, 1, 0, 0, 32'h8000_0140, 32'h0, size4);
        setLane(0, 1, 0, 1, 32'h8000_0144, 32'h0, size4);
        applyAndWait();
        setLane(1, 0, 0, 0, 32'h0, 32'h0, size4);
        setLane(0, 0, 0, 0, 32'h0, 32'h0, size4);
        applyAndWait();
        // lane 0 load sees the older lane 1 store
        setLane(1, 0, 1, 0, 32'h8000_0152, 32'h0000_5566, size2);
        setLane(0, 1, 0, 0, 32'h8000_0150, 32'h0, size4);
        applyAndWait();
        for (k = 0; k < 3; k++) begin
            setLane(1, 0, 1, 0, 32'h8000_0200 + 8 * k, 32'hA5A5_0000 + k, size4);
            setLane(0, 0, 1, 0, 32'h8000_0204 + 9 * k, 32'h0000_0090 + k, size1);
            applyAndWait();
            setLane(1, 1, 0, 0, 32'h8000_0204 + 8 * k, 32'h0, size4);
            setLane(0, 1, 0, 0, 32'hA000_0200 + 8 * k, 32'h0, size4);
            applyAndWait();
        end

        repeat (2) @(posedge clk);
        if (errCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== storeAlign.sv ====
`timescale 1ns/1ps

module storeAlign (
    input  logic [1:0]          addrLow,
    input  logic [31:0]         srcData,
    input  memStagePkg::accSize size,
    output logic [31:0]         wdata,
    output logic [3:0]          strobe,
    output logic                misalign
);
    import memStagePkg::*;

    logic [1:0] offset;

    assign offset = addrLow;

    always_comb begin
        wdata    = srcData;
        strobe   = 4'b0000;
        misalign = 1'b0;
        case (size)
            size1: begin
                // byte copied to every lane and the strobe picks one
                wdata  = {4{srcData[7:0]}};
                strobe = 4'b0001 << offset;
            end
            size2: begin
                wdata    = {2{srcData[15:0]}};
                strobe   = offset[1] ? 4'b1100 : 4'b0011;
                misalign = offset[0];
            end
            size4: begin
                wdata    = srcData;
                strobe   = 4'b1111;
                misalign = (offset != 2'b00);
            end
            default: begin
                // unused encoding writes nothing
                strobe = 4'b0000;
            end
        endcase
    end

endmodule

// ==== tbWbMemory.sv ====
`timescale 1ns/1ps
`include "memStage_consts.svh"

module tbWbMemory (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 wbCyc,
    input  logic                 wbStb,
    input  logic                 wbWe,
    input  logic [`WB_ADR_W-1:0] wbAdr,
    input  logic [3:0]           wbSel,
    input  logic [31:0]          wbDatW,
    output logic [31:0]          wbDatR,
    output logic                 wbAck
);

    logic [31:0] mem [`TB_MEM_WORDS];
    logic [15:0] lfsr;
    logic [15:0] lfsrOne;
    logic [15:0] lfsrTwo;
    logic [1:0]  waitCycles;
    logic [1:0]  waitCnt;
    int          index;

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    assign lfsrOne = lfsrStep(lfsr);
    assign lfsrTwo = lfsrStep(lfsrOne);
    assign index   = wbAdr % `TB_MEM_WORDS;
    assign wbDatR  = mem[index];
    // ack once the strobe has waited waitCycles cycles
    assign wbAck   = wbCyc && wbStb && (waitCnt == waitCycles);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            lfsr       <= 16'd22;
            waitCycles <= 2'd0;
            waitCnt    <= 2'd0;
        end else if (wbAck) begin
            // one step for each bit of the next delay
            lfsr       <= lfsrTwo;
            waitCycles <= {lfsrOne[0], lfsrTwo[0]};
            waitCnt    <= 2'd0;
        end else if (wbCyc && wbStb) begin
            waitCnt <= waitCnt + 2'd1;
        end
    end

    always @(posedge clk) begin
        if (wbAck && wbWe) begin
            for (int b = 0; b < 4; b++) begin
                if (wbSel[b]) begin
                    mem[index][8*b +: 8] <= wbDatW[8*b +: 8];
                end
            end
        end
    end

endmodule
